//--- cache_top.f
design/cache_pkg.sv
design/cache_ctrl.sv
design/tagv_array.sv
design/store_buffer.sv
design/data_bank_arbiter.sv
design/data_banks.sv
design/cache_top.sv
verification/cache_checker.sv
verification/cache_monitor.sv
verification/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb \
    -f cache_top.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
exit 0

//--- verification/cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    localparam int random_requests = 200;
    localparam int stall_requests  = 100;
    localparam int total_requests  = 12 + 8 + 3 + 2 + random_requests + stall_requests;
    localparam int cycles_per_request = 200;
    localparam int timeout_cycles  = total_requests * cycles_per_request + 100;
    localparam logic [31:0] seed   = 32'hdd5bffcb;

    logic      clk;
    logic      resetn;
    logic      valid;
    logic      op;
    index_t    index;
    tag_t      tag;
    offset_t   offset;
    strb_t     wstrb;
    word_t     wdata;
    logic      rd_rdy;
    logic      ret_valid;
    logic      ret_last;
    word_t     ret_data;
    logic      wr_rdy;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    logic      rd_req;
    mem_addr_t rd_addr;
    logic      wr_req;
    mem_addr_t wr_addr;
    line_t     wr_data;

    logic        expect_hit;
    logic        test_done;
    logic        all_done;
    int          test_id;
    int          error_count;
    logic        timed_out;
    logic        stall_mode;     // long rd_rdy / wr_rdy low stretches
    logic [31:0] stim_lfsr;
    logic [31:0] mem_lfsr;
    word_t       mem_words [mem_addr_t];
    mem_addr_t   rd_line;
    int          beats_left;
    int          beat;

    cache_top i_cache_top (.*);

    cache_monitor #(.timeout_cycles(timeout_cycles)) i_cache_monitor (.*);

    bind cache_top cache_checker i_cache_checker (
        .clk(clk), .resetn(resetn), .valid(valid), .addr_ok(addr_ok),
        .data_ok(data_ok), .rd_req(rd_req), .rd_rdy(rd_rdy), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_rdy(wr_rdy), .wr_addr(wr_addr)
    );

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = galois_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            mem_lfsr = galois_step(mem_lfsr);
            v = {v[30:0], mem_lfsr[0]};
        end
        return v;
    endfunction

    // untouched memory is a function of the whole address
    function automatic word_t mem_word(input mem_addr_t a);
        if (mem_words.exists(a))
            return mem_words[a];
        return (a * 32'h9e3779b9) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // starts on a falling edge and returns on the falling edge after data_ok
    task automatic do_request(input logic st, input tag_t t, input index_t i,
                              input bank_t b, input strb_t s, input word_t d);
        valid = 1'b1;
        op = st;
        tag = t;
        index = i;
        offset = {b, 2'b00};
        wstrb = s;
        wdata = d;
        while (!addr_ok)
            @(negedge clk);
        @(negedge clk);
        valid = 1'b0;
        do
            @(posedge clk);    // data_ok settled before the edge
        while (!data_ok);
        @(negedge clk);
    endtask

    task automatic random_request();
        logic   st;
        tag_t   t;
        index_t i;
        bank_t  b;
        strb_t  s;
        word_t  d;
        st = stim_bits(1) != 0;
        t = tag_t'(32'h00040 + stim_bits(2));    // four tags fight over each set
        i = index_t'(32'h30 + stim_bits(2));
        b = bank_t'(stim_bits(2));
        s = strb_t'(stim_bits(4));
        d = stim_bits(32);
        do_request(st, t, i, b, s, d);
    endtask

    task automatic finish_test(input int id);
        test_id = id;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        stim_lfsr = seed;
        resetn = 1'b0;
        valid = 1'b0;
        op = 1'b0;
        index = '0;
        tag = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        expect_hit = 1'b0;
        test_done = 1'b0;
        all_done = 1'b0;
        test_id = 0;
        stall_mode = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        for (int l = 0; l < 3; l++) begin    // cold misses
            for (int b = 0; b < 4; b++)
                do_request(1'b0, 20'h00012, index_t'(8'h10 + l), bank_t'(b), 4'h0, '0);
        end
        finish_test(1);

        expect_hit = 1'b1;
        for (int r = 0; r < 2; r++) begin
            for (int b = 0; b < 4; b++)
                do_request(1'b0, 20'h00012, 8'h11, bank_t'(b), 4'h0, '0);
        end
        finish_test(2);

        do_request(1'b1, 20'h00012, 8'h10, 2'd1, 4'b0101, 32'hcafef00d);
        do_request(1'b0, 20'h00012, 8'h10, 2'd1, 4'h0, '0);
        do_request(1'b0, 20'h00012, 8'h10, 2'd2, 4'h0, '0);
        expect_hit = 1'b0;
        finish_test(3);

        do_request(1'b1, 20'h00777, 8'h20, 2'd3, 4'b1110, 32'h12345678);
        expect_hit = 1'b1;
        do_request(1'b0, 20'h00777, 8'h20, 2'd3, 4'h0, '0);
        expect_hit = 1'b0;
        finish_test(4);

        repeat (random_requests) random_request();
        finish_test(5);

        stall_mode = 1'b1;
        repeat (stall_requests) random_request();
        stall_mode = 1'b0;
        finish_test(6);

        all_done = 1'b1;
        @(negedge clk);
        all_done = 1'b0;
        if (error_count == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    always @(negedge clk) begin
        if (timed_out) begin
            $display("** FAIL **");
            $finish;
        end
    end

    // memory responder samples on rising edges and drives on falling edges
    initial begin
        mem_lfsr = seed;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        beats_left = 0;
        beat = 0;
        rd_line = '0;
        forever begin
            @(posedge clk);
            if (rd_req && rd_rdy) begin
                rd_line = rd_addr;
                beats_left = 4;
                beat = 0;
            end
            if (wr_req && wr_rdy) begin
                for (int b = 0; b < 4; b++)
                    mem_words[wr_addr + mem_addr_t'(b*4)] = wr_data[b*32 +: 32];
            end
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last = 1'b0;
            if (beats_left > 0 && mem_bits(2) != 0) begin   // gap one beat in four
                ret_valid = 1'b1;
                ret_data = mem_word(rd_line + mem_addr_t'(beat*4));
                ret_last = (beats_left == 1);
                beat++;
                beats_left--;
            end
            if (stall_mode) begin
                rd_rdy = mem_bits(3) == 0;
                wr_rdy = mem_bits(3) == 0;
            end else begin
                rd_rdy = mem_bits(2) != 0;
                wr_rdy = mem_bits(2) != 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/cache_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module cache_monitor #(
    parameter int timeout_cycles = 1000
) (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       valid,
    input  wire                       op,
    input  wire cache_pkg::index_t    index,
    input  wire cache_pkg::tag_t      tag,
    input  wire cache_pkg::offset_t   offset,
    input  wire cache_pkg::strb_t     wstrb,
    input  wire cache_pkg::word_t     wdata,
    input  wire                       addr_ok,
    input  wire                       data_ok,
    input  wire cache_pkg::word_t     rdata,
    input  wire                       wr_req,
    input  wire                       wr_rdy,
    input  wire cache_pkg::mem_addr_t wr_addr,
    input  wire cache_pkg::line_t     wr_data,
    input  wire                       expect_hit,
    input  wire                       test_done,
    input  int                        test_id,
    input  wire                       all_done,
    output int                        error_count,
    output logic                      timed_out
);

    import cache_pkg::*;

    word_t     shadow [mem_addr_t];     // what memory should hold
    logic      pending;
    logic      pend_op;
    logic      check_addr_ok;
    word_t     pend_exp;
    mem_addr_t pend_addr;
    mem_addr_t acc_addr;
    word_t     merged;
    word_t     exp_word;
    int        latency;
    int        cycles;
    int        checks;
    int        test_checks;
    int        test_errors;

    function automatic word_t init_word(input mem_addr_t a);
        return (a * 32'h9e3779b9) ^ {a[15:0], a[31:16]};
    endfunction

    // reference model of a load
    function automatic word_t expected_word(input mem_addr_t a);
        if (shadow.exists(a))
            return shadow[a];
        return init_word(a);
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic count_check();
        checks++;
        test_checks++;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            pending = 1'b0;
            check_addr_ok = 1'b0;
            cycles = 0;
            checks = 0;
            test_checks = 0;
            test_errors = 0;
            error_count = 0;
            timed_out = 1'b0;
        end else begin
            cycles++;
            if (cycles == timeout_cycles) begin
                $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
                timed_out = 1'b1;
                count_error();
            end
            // store buffer write cycle blocks new requests
            if (check_addr_ok) begin
                check_addr_ok = 1'b0;
                count_check();
                if (addr_ok) begin
                    $display("addr_ok was high in the cycle after a store hit");
                    count_error();
                end
            end
            if (pending)
                latency++;
            if (data_ok) begin
                if (!pending) begin
                    $display("data_ok came without an accepted request");
                    count_error();
                end else begin
                    pending = 1'b0;
                    count_check();
                    if (expect_hit && latency != 1) begin
                        $display("hit at %h took %0d cycles to data_ok instead of 1",
                                 pend_addr, latency);
                        count_error();
                    end
                    if (!pend_op && rdata !== pend_exp) begin
                        $display("CHECK FAILED rdata at %h: got %h expected %h",
                                 pend_addr, rdata, pend_exp);
                        count_error();
                    end
                    if (pend_op && latency == 1)
                        check_addr_ok = 1'b1;
                end
            end
            if (valid && addr_ok) begin
                acc_addr = {tag, index, offset[3:2], 2'b00};
                pending = 1'b1;
                latency = 0;
                pend_op = op;
                pend_addr = acc_addr;
                pend_exp = expected_word(acc_addr);
                if (op) begin
                    merged = pend_exp;
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb[i])
                            merged[i*8 +: 8] = wdata[i*8 +: 8];
                    end
                    shadow[acc_addr] = merged;
                end
            end
            if (wr_req && wr_rdy) begin
                for (int b = 0; b < 4; b++) begin
                    exp_word = expected_word(wr_addr + mem_addr_t'(b*4));
                    count_check();
                    if (wr_data[b*32 +: 32] !== exp_word) begin
                        $display("CHECK FAILED wr_data word %0d at %h: got %h expected %h",
                                 b, wr_addr, wr_data[b*32 +: 32], exp_word);
                        count_error();
                    end
                end
            end
            if (test_done) begin
                $display("test %0d finished: %0d checks, %0d errors",
                         test_id, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (all_done)
                $display("all tests: %0d checks, %0d errors", checks, error_count);
        end
    end

endmodule

`default_nettype wire

//--- verification/cache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cache_checker (
    input wire                       clk,
    input wire                       resetn,
    input wire                       valid,
    input wire                       addr_ok,
    input wire                       data_ok,
    input wire                       rd_req,
    input wire                       rd_rdy,
    input wire cache_pkg::mem_addr_t rd_addr,
    input wire                       wr_req,
    input wire                       wr_rdy,
    input wire cache_pkg::mem_addr_t wr_addr
);

    logic outstanding;    // a request was taken and not yet answered

    always_ff @(posedge clk) begin
        if (!resetn)
            outstanding <= 1'b0;
        else if (valid && addr_ok)
            outstanding <= 1'b1;
        else if (data_ok)
            outstanding <= 1'b0;
    end

    quiet_after_reset: assert property (@(posedge clk)
        !resetn |=> !data_ok && !rd_req && !wr_req)
        else $error("data_ok, rd_req or wr_req active right after reset");

    rd_addr_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("rd_req dropped or rd_addr changed while waiting");

    wr_addr_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
        else $error("wr_req dropped or wr_addr changed while waiting");

    no_spurious_data_ok: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> outstanding)
        else $error("data_ok without an accepted request");

endmodule

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         valid,
    input  wire                         op,
    input  wire cache_pkg::index_t      index,
    input  wire cache_pkg::tag_t        tag,
    input  wire cache_pkg::offset_t     offset,
    input  wire cache_pkg::strb_t       wstrb,
    input  wire cache_pkg::word_t       wdata,
    input  wire                         rd_rdy,
    input  wire                         ret_valid,
    input  wire                         ret_last,
    input  wire cache_pkg::word_t       ret_data,
    input  wire                         wr_rdy,
    output logic                        addr_ok,
    output logic                        data_ok,
    output cache_pkg::word_t            rdata,
    output logic                        rd_req,
    output cache_pkg::mem_addr_t        rd_addr,
    output logic                        wr_req,
    output cache_pkg::mem_addr_t        wr_addr,
    output cache_pkg::line_t            wr_data
);

    import cache_pkg::*;

    // controller to the rest
    ctrl_state_t state;
    index_t      lookup_index;
    index_t      req_index;
    tag_t        req_tag;
    bank_t       req_bank;
    logic        req_op;
    strb_t       req_wstrb;
    word_t       req_wdata;
    logic        refill_we;
    bank_t       refill_bank;
    word_t       refill_word;
    logic        refill_done;
    way_t        victim_way;

    // tag store
    logic [num_ways-1:0] way_hit;
    tag_t                victim_tag;
    logic                victim_valid;
    logic                victim_dirty;

    // store buffer
    logic   sb_busy;
    way_t   sb_way;
    index_t sb_index;
    bank_t  sb_bank;
    strb_t  sb_wstrb;
    word_t  sb_word;

    // bank ports and read data
    index_t [num_ways*num_banks-1:0] bank_index;
    strb_t  [num_ways*num_banks-1:0] bank_we;
    word_t                           bank_wdata;
    word_t                           hit_word;
    line_t                           victim_line;

    cache_ctrl        i_cache_ctrl        (.*);
    tagv_array        i_tagv_array        (.sb_we(sb_busy), .*);
    store_buffer      i_store_buffer      (.*);
    data_bank_arbiter i_data_bank_arbiter (.*);
    data_banks        i_data_banks        (.*);

endmodule

`default_nettype wire

//--- design/data_banks.sv
`timescale 1ns/10ps
`default_nettype none

module data_banks (
    input  wire                           clk,
    input  wire cache_pkg::index_t [cache_pkg::num_ways*cache_pkg::num_banks-1:0] bank_index,
    input  wire cache_pkg::strb_t  [cache_pkg::num_ways*cache_pkg::num_banks-1:0] bank_we,
    input  wire cache_pkg::word_t         bank_wdata,
    input  wire cache_pkg::bank_t         req_bank,
    input  wire [cache_pkg::num_ways-1:0] way_hit,
    input  wire cache_pkg::way_t          victim_way,
    output cache_pkg::word_t              hit_word,
    output cache_pkg::line_t              victim_line
);

    import cache_pkg::*;

    word_t [num_ways*num_banks-1:0] rd_words;   // port p is way p/4, bank p%4

    for (genvar p = 0; p < num_ways*num_banks; p++) begin : g_bank
        word_t mem [num_sets];
        word_t rd_q;

        // byte-enable write, registered read
        always_ff @(posedge clk) begin
            for (int i = 0; i < 4; i++) begin
                if (bank_we[p][i])
                    mem[bank_index[p]][i*8 +: 8] <= bank_wdata[i*8 +: 8];
            end
            rd_q <= mem[bank_index[p]];
        end

        assign rd_words[p] = rd_q;
    end

    // at most one way hits
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_hit[w])
                hit_word = hit_word | rd_words[w*num_banks + int'(req_bank)];
        end
    end

    always_comb begin
        for (int b = 0; b < num_banks; b++)
            victim_line[b*32 +: 32] = rd_words[int'(victim_way)*num_banks + b];
    end

endmodule

`default_nettype wire

//--- design/data_bank_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module data_bank_arbiter (
    input  wire cache_pkg::ctrl_state_t   state,
    input  wire cache_pkg::index_t        lookup_index,
    input  wire cache_pkg::index_t        req_index,
    input  wire cache_pkg::way_t          victim_way,
    input  wire                           refill_we,
    input  wire cache_pkg::bank_t         refill_bank,
    input  wire cache_pkg::word_t         refill_word,
    input  wire                           sb_busy,
    input  wire cache_pkg::way_t          sb_way,
    input  wire cache_pkg::index_t        sb_index,
    input  wire cache_pkg::bank_t         sb_bank,
    input  wire cache_pkg::strb_t         sb_wstrb,
    input  wire cache_pkg::word_t         sb_word,
    output cache_pkg::index_t [cache_pkg::num_ways*cache_pkg::num_banks-1:0] bank_index,
    output cache_pkg::strb_t  [cache_pkg::num_ways*cache_pkg::num_banks-1:0] bank_we,
    output cache_pkg::word_t              bank_wdata
);

    import cache_pkg::*;

    logic refill_active;

    // refill beats only land while the controller is refilling
    assign refill_active = refill_we && (state == refill);

    // one shared write bus, refill and store buffer never overlap
    assign bank_wdata = refill_active ? refill_word : sb_word;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            for (int b = 0; b < num_banks; b++) begin
                if (refill_active && victim_way == way_t'(w) &&
                    refill_bank == bank_t'(b)) begin
                    // whole word from memory
                    bank_index[w*num_banks + b] = req_index;
                    bank_we[w*num_banks + b]    = '1;
                end else if (sb_busy && sb_way == way_t'(w) &&
                             sb_bank == bank_t'(b)) begin
                    bank_index[w*num_banks + b] = sb_index;
                    bank_we[w*num_banks + b]    = sb_wstrb;
                end else begin
                    bank_index[w*num_banks + b] = lookup_index;   // plain read
                    bank_we[w*num_banks + b]    = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/store_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module store_buffer (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire cache_pkg::ctrl_state_t   state,
    input  wire [cache_pkg::num_ways-1:0] way_hit,
    input  wire                           req_op,
    input  wire cache_pkg::index_t        req_index,
    input  wire cache_pkg::bank_t         req_bank,
    input  wire cache_pkg::strb_t         req_wstrb,
    input  wire cache_pkg::word_t         req_wdata,
    output logic                          sb_busy,
    output cache_pkg::way_t               sb_way,
    output cache_pkg::index_t             sb_index,
    output cache_pkg::bank_t              sb_bank,
    output cache_pkg::strb_t              sb_wstrb,
    output cache_pkg::word_t              sb_word
);

    import cache_pkg::*;

    logic store_hit;

    assign store_hit = (state == lookup) && req_op && (|way_hit);

    // busy exactly the cycle after the hit
    always_ff @(posedge clk) begin
        if (!resetn)
            sb_busy <= 1'b0;
        else
            sb_busy <= store_hit;
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            sb_way   <= way_t'(way_hit[1]);
            sb_index <= req_index;
            sb_bank  <= req_bank;
            sb_wstrb <= req_wstrb;
            sb_word  <= req_wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/tagv_array.sv
`timescale 1ns/10ps
`default_nettype none

module tagv_array (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire cache_pkg::index_t        lookup_index,
    input  wire cache_pkg::index_t        req_index,
    input  wire cache_pkg::tag_t          req_tag,
    input  wire cache_pkg::ctrl_state_t   state,
    input  wire cache_pkg::way_t          victim_way,
    input  wire                           refill_done,
    input  wire                           req_op,
    input  wire                           sb_we,
    input  wire cache_pkg::way_t          sb_way,
    input  wire cache_pkg::index_t        sb_index,
    output logic [cache_pkg::num_ways-1:0] way_hit,
    output cache_pkg::tag_t               victim_tag,
    output logic                          victim_valid,
    output logic                          victim_dirty
);

    import cache_pkg::*;

    tag_t                               tag_ram [num_ways][num_sets];
    tag_t [num_ways-1:0]                tag_q;
    logic [num_ways-1:0][num_sets-1:0]  valid_bits;
    logic [num_ways-1:0][num_sets-1:0]  dirty_bits;
    logic [num_ways-1:0]                valid_q;

    // tag ram with registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (refill_done && victim_way == way_t'(w))
                tag_ram[w][req_index] <= req_tag;
            tag_q[w] <= tag_ram[w][lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++)
                valid_q[w] <= valid_bits[w][lookup_index];
            if (refill_done) begin
                valid_bits[victim_way][req_index] <= 1'b1;
                dirty_bits[victim_way][req_index] <= req_op;  // store miss leaves it dirty
            end
            if (sb_we)
                dirty_bits[sb_way][sb_index] <= 1'b1;
        end
    end

    // hit only means something during lookup
    always_comb begin
        for (int w = 0; w < num_ways; w++)
            way_hit[w] = (state == lookup) && valid_q[w] && (tag_q[w] == req_tag);
    end

    assign victim_tag   = tag_q[victim_way];
    assign victim_valid = valid_q[victim_way];
    assign victim_dirty = dirty_bits[victim_way][req_index];   // not registered

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           valid,
    input  wire                           op,
    input  wire cache_pkg::index_t        index,
    input  wire cache_pkg::tag_t          tag,
    input  wire cache_pkg::offset_t       offset,
    input  wire cache_pkg::strb_t         wstrb,
    input  wire cache_pkg::word_t         wdata,
    input  wire                           sb_busy,
    input  wire [cache_pkg::num_ways-1:0] way_hit,
    input  wire cache_pkg::tag_t          victim_tag,
    input  wire                           victim_valid,
    input  wire                           victim_dirty,
    input  wire cache_pkg::word_t         hit_word,
    input  wire cache_pkg::line_t         victim_line,
    input  wire                           rd_rdy,
    input  wire                           ret_valid,
    input  wire                           ret_last,
    input  wire cache_pkg::word_t         ret_data,
    input  wire                           wr_rdy,
    output logic                          addr_ok,
    output logic                          data_ok,
    output cache_pkg::word_t              rdata,
    output cache_pkg::ctrl_state_t        state,
    output cache_pkg::index_t             lookup_index,
    output cache_pkg::index_t             req_index,
    output cache_pkg::tag_t               req_tag,
    output cache_pkg::bank_t              req_bank,
    output logic                          req_op,
    output cache_pkg::strb_t              req_wstrb,
    output cache_pkg::word_t              req_wdata,
    output logic                          refill_we,
    output cache_pkg::bank_t              refill_bank,
    output cache_pkg::word_t              refill_word,
    output logic                          refill_done,
    output cache_pkg::way_t               victim_way,
    output logic                          rd_req,
    output cache_pkg::mem_addr_t          rd_addr,
    output logic                          wr_req,
    output cache_pkg::mem_addr_t          wr_addr,
    output cache_pkg::line_t              wr_data
);

    import cache_pkg::*;

    ctrl_state_t state_nxt;
    logic        accept;
    logic        cache_hit;
    logic        need_wb;       // victim has to go back first
    word_t       store_mask;
    word_t       miss_word;
    lfsr_t       lfsr;

    assign accept    = valid & addr_ok;
    assign cache_hit = |way_hit;
    assign need_wb   = victim_valid & victim_dirty;

    // new requests wait while a store hit is still pending
    assign addr_ok = (state == idle) & ~sb_busy;
    assign data_ok = ((state == lookup) & cache_hit) | refill_done;

    always_comb begin
        if (state == lookup)
            rdata = hit_word;
        else if (refill_bank == req_bank)
            rdata = ret_data;      // wanted word is the current beat
        else
            rdata = miss_word;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle:
                if (accept)
                    state_nxt = lookup;
            lookup:
                state_nxt = cache_hit ? idle : miss;
            miss:
                if (!need_wb || wr_rdy)
                    state_nxt = replace;
            replace:
                if (rd_rdy)
                    state_nxt = refill;
            refill:
                if (refill_done)
                    state_nxt = idle;
            default:
                state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[3:2];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // rams see the live index only while a request can be taken
    assign lookup_index = (state == idle) ? index : req_index;

    assign refill_we   = (state == refill) & ret_valid;
    assign refill_done = refill_we & ret_last;

    assign store_mask = {{8{req_wstrb[3]}}, {8{req_wstrb[2]}},
                         {8{req_wstrb[1]}}, {8{req_wstrb[0]}}};

    // store miss merges its bytes into the matching beat
    assign refill_word = (req_op && refill_bank == req_bank) ?
                         (req_wdata & store_mask) | (ret_data & ~store_mask) :
                         ret_data;

    always_ff @(posedge clk) begin
        if (!resetn)
            refill_bank <= '0;
        else if (refill_done)
            refill_bank <= '0;
        else if (refill_we)
            refill_bank <= refill_bank + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (refill_we && refill_bank == req_bank)
            miss_word <= ret_data;
    end

    // taps 8,6,5,4
    always_ff @(posedge clk) begin
        if (!resetn)
            lfsr <= 8'h01;
        else if (refill_done)
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end

    assign victim_way = lfsr[0];

    assign rd_req  = (state == replace);
    assign rd_addr = {req_tag, req_index, 4'b0000};
    assign wr_req  = (state == miss) & need_wb;
    assign wr_addr = {victim_tag, req_index, 4'b0000};
    assign wr_data = victim_line;

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // cache geometry
    localparam int num_ways  = 2;
    localparam int num_banks = 4;    // 32-bit words per line
    localparam int num_sets  = 256;

    // address split is tag[31:12] index[11:4] offset[3:0]
    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;
    typedef logic [1:0]   bank_t;     // word in line, also refill beat
    typedef logic         way_t;

    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;
    typedef logic [31:0]  mem_addr_t;

    typedef logic [7:0]   lfsr_t;     // victim way picker

    // main controller states
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,       // victim write-back
        replace,    // line read request
        refill
    } ctrl_state_t;

endpackage

`default_nettype wire
